//--- compile.f
source/icache_pkg.sv
source/cache_array_if.sv
source/sync_ram.sv
source/icache_arrays.sv
source/icache_ctrl.sv
source/icache_top.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

//--- verif/fetch_input.txt
# op (F fetch, I invalidate)  byte address  kill  expected word
# Each set holds at most one line at a time, so hits and misses are known
F 1010 0 0404FBFB
F 1014 0 0405FBFA
F 101C 0 0407FBF8
F 3020 0 0C08F3F7
F 4034 0 100DEFF2
F 5008 0 1402EBFD
I 1010 0 00000000
F 1018 0 0406FBF9
F 1014 0 0405FBFA
I 3024 0 00000000
F 302C 0 0C0BF3F4
F 7038 1 00000000
F 4030 0 100CEFF3
F 3028 0 0C0AF3F5
F 5004 0 1401EBFE
F 4038 0 100EEFF1

//--- verif/icache_tb.sv
`timescale 1ns/1ps
/*
   Operations run one at a time; filler fetches between them are always killed.
   Bus word for byte address B is {B>>2, ~(B>>2)}; AR and beat delays are 0 to 3 cycles.
*/
module icache_tb;
   import icache_pkg::*;

   localparam int VPO_W   = 12;
   localparam int N_BEATS = 4;
   localparam int MAX_OPS = 64;

   logic clk = 1'b0;
   logic i_reset, i_kill, i_inv_we, i_ar_ready, i_r_valid, i_r_last;
   logic [VPO_W-1:0]        i_vpo;
   logic [ADDR_W-VPO_W-1:0] i_ppn;
   logic [ADDR_W-1:0]       i_inv_paddr;
   insn_t                   i_r_data;
   logic                    o_stall, o_valid, o_ar_valid, o_r_ready;
   insn_t                   o_ins;
   logic [ADDR_W-1:0]       o_ar_addr;

   logic [7:0]        op_code [MAX_OPS];
   logic [ADDR_W-1:0] op_addr [MAX_OPS];
   logic              op_kill [MAX_OPS];
   insn_t             op_exp  [MAX_OPS];
   bit                resident [4096];   // Per line number
   int  n_ops, errors, checks, cyc, limit, ar_count, seed;
   logic              ar_wait;
   logic [ADDR_W-1:0] last_ar_addr;

   icache_top dut_i (.*);

   always #2 clk = ~clk;

   function automatic insn_t bus_word(input logic [ADDR_W-1:0] byte_addr);
      logic [15:0] a;
      a = 16'(byte_addr >> 2);
      return {a, ~a};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (o_stall)
         @(negedge clk);
   endtask

   task automatic fetch_word(input logic [ADDR_W-1:0] addr, input logic kill, input insn_t exp);
      int   lat;
      int   ar_before;
      logic hit_exp;
      hit_exp = resident[addr[ADDR_W-1:4]];
      wait_idle();
      ar_before = ar_count;
      @(posedge clk);
      i_vpo <= addr[VPO_W-1:0];          // Request edge
      @(posedge clk);
      i_ppn  <= addr[ADDR_W-1:VPO_W];
      i_kill <= kill;
      i_vpo  <= '0;                      // Filler fetch
      @(posedge clk);
      i_kill <= 1'b1;
      if (kill)
      begin
         repeat (8)
         begin
            @(negedge clk);
            check("o_valid", 32'(o_valid), 32'd0);
         end
         check("AR handshakes", 32'(ar_count - ar_before), 32'd0);
      end
      else
      begin
         lat = 2;
         @(negedge clk);
         while (!o_valid)
         begin
            @(negedge clk);
            lat++;
         end
         check("o_ins", o_ins, exp);
         if (hit_exp)
         begin
            check("hit latency", 32'(lat), 32'd2);
            check("AR handshakes", 32'(ar_count - ar_before), 32'd0);
         end
         else
         begin
            check("AR handshakes", 32'(ar_count - ar_before), 32'd1);
            check("o_ar_addr", 32'(last_ar_addr), 32'({addr[ADDR_W-1:4], 4'h0}));
            resident[addr[ADDR_W-1:4]] = 1'b1;
         end
      end
   endtask

   task automatic invalidate_line(input logic [ADDR_W-1:0] addr);
      int ar_before;
      wait_idle();
      ar_before = ar_count;
      @(posedge clk);
      i_inv_we    <= 1'b1;
      i_inv_paddr <= addr;
      @(posedge clk);
      i_inv_we <= 1'b0;
      wait_idle();
      check("AR handshakes", 32'(ar_count - ar_before), 32'd0);
      for (int i = 0; i < 4096; i++)
      begin
         if (i[1:0] == addr[5:4])
            resident[i] = 1'b0;          // Both ways of the set
      end
   endtask

   // AR handshake monitor
   always @(negedge clk)
   begin
      if (ar_wait && !o_ar_valid)
      begin
         errors++;
         $display("o_ar_valid dropped at %0t before i_ar_ready was seen", $time);
      end
      if (o_ar_valid && i_ar_ready)
      begin
         ar_count++;
         last_ar_addr = o_ar_addr;
      end
      ar_wait = o_ar_valid && !i_ar_ready;
   end

   // R channel ready, high for every offered beat and low while idle
   always @(negedge clk)
   begin
      if (i_r_valid)
         check("o_r_ready", 32'(o_r_ready), 32'd1);
      else if (!o_stall)
         check("o_r_ready", 32'(o_r_ready), 32'd0);
   end

   // Bus memory model
   initial
   begin
      int d;
      logic [ADDR_W-1:0] base;
      forever
      begin
         @(negedge clk);
         if (o_ar_valid)
         begin
            base = o_ar_addr;
            d = $unsigned($random(seed)) % 4;
            repeat (d) @(posedge clk);
            @(posedge clk);
            i_ar_ready <= 1'b1;
            @(posedge clk);
            i_ar_ready <= 1'b0;
            for (int b = 0; b < N_BEATS; b++)
            begin
               d = $unsigned($random(seed)) % 4;
               repeat (d)
               begin
                  i_r_valid <= 1'b0;
                  @(posedge clk);
               end
               i_r_valid <= 1'b1;
               i_r_data  <= bus_word(base + ADDR_W'(4 * b));
               i_r_last  <= (b == N_BEATS - 1);
               @(posedge clk);
            end
            i_r_valid <= 1'b0;
            i_r_last  <= 1'b0;
         end
      end
   end

   always @(posedge clk)
   begin
      cyc++;
      if (limit > 0 && cyc >= limit)
      begin
         $display("Timeout after %0d cycles, checks %0d errors %0d", cyc, checks, errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial
   begin
      int    fd;
      int    boot_cycles;
      string line;
      seed = 95;
      i_reset <= 1'b1;
      i_kill <= 1'b1;
      i_vpo <= '0;
      i_ppn <= '0;
      i_inv_we <= 1'b0;
      i_inv_paddr <= '0;
      i_ar_ready <= 1'b0;
      i_r_valid <= 1'b0;
      i_r_data <= '0;
      i_r_last <= 1'b0;
      fd = $fopen("verif/fetch_input.txt", "r");
      if (fd == 0)
         $display("Could not open the stimulus file");
      while (fd != 0 && !$feof(fd) && n_ops < MAX_OPS)
      begin
         line = "";                      // Empty when the read hits the end
         void'($fgets(line, fd));
         if (line.len() > 3 && line[0] != "#")
         begin
            void'($sscanf(line, "%c %h %d %h", op_code[n_ops], op_addr[n_ops],
                          op_kill[n_ops], op_exp[n_ops]));
            n_ops++;
         end
      end
      limit = n_ops * 200 + 100;
      if (n_ops == 0)
         errors++;
      repeat (16) @(posedge clk);
      i_reset <= 1'b0;
      boot_cycles = 0;
      @(negedge clk);
      while (o_stall)
      begin
         check("o_valid", 32'(o_valid), 32'd0);
         boot_cycles++;
         @(negedge clk);
      end
      check("boot stall at least 4 cycles", 32'(boot_cycles >= 4), 32'd1);
      for (int k = 0; k < n_ops; k++)
      begin
         if (op_code[k] == "I")
            invalidate_line(op_addr[k]);
         else
            fetch_word(op_addr[k], op_kill[k], op_exp[k]);
      end
      $display("Done: %0d operations, %0d checks, %0d errors", n_ops, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- source/icache_top.sv
`timescale 1ns/1ps
/*
   A fetch is taken at every edge with o_stall low, so i_vpo must always be a real address.
   Hold i_vpo, i_ppn and i_kill steady while o_stall is high; i_inv_we is seen only when it is low.
*/
module icache_top
(
   input  logic                                      clk,
   input  logic                                      i_reset,
   input  logic [icache_pkg::PAGE_W-1:0]             i_vpo,
   input  logic [icache_pkg::ADDR_W-icache_pkg::PAGE_W-1:0] i_ppn,
   input  logic                                      i_kill,
   input  logic                                      i_inv_we,
   input  logic [icache_pkg::ADDR_W-1:0]             i_inv_paddr,
   output logic                                      o_stall,
   output icache_pkg::insn_t                         o_ins,
   output logic                                      o_valid,
   output logic                                      o_ar_valid,
   input  logic                                      i_ar_ready,
   output logic [icache_pkg::ADDR_W-1:0]             o_ar_addr,
   input  logic                                      i_r_valid,
   output logic                                      o_r_ready,
   input  icache_pkg::insn_t                         i_r_data,
   input  logic                                      i_r_last
);
   import icache_pkg::*;

   logic                s1_valid;
   logic [PAGE_W-1:0]   s1_vpo;
   logic [SET_W-1:0]    s1_set;
   logic [PAY_AW-1:0]   s1_pay_addr;
   logic                s2_valid;
   logic [ADDR_W-1:0]   s2_paddr;
   logic [ADDR_W-1:0]   inv_paddr_q;
   logic                refill_hit_word;
   logic                refill_beat;

   cache_array_if arr_if ();

   assign s2_paddr = {i_ppn, s1_vpo};   // Physical address in the compare cycle

   icache_ctrl u_ctrl
   (
      .clk               (clk),
      .i_reset           (i_reset),
      .arr               (arr_if),
      .i_vpo             (i_vpo),
      .i_s1_valid        (s1_valid),
      .i_s1_set          (s1_set),
      .i_s1_pay_addr     (s1_pay_addr),
      .i_s2_paddr        (s2_paddr),
      .i_kill            (i_kill),
      .i_inv_we          (i_inv_we),
      .i_inv_paddr       (inv_paddr_q),
      .o_stall           (o_stall),
      .o_refill_hit_word (refill_hit_word),
      .o_refill_beat     (refill_beat),
      .o_ar_valid        (o_ar_valid),
      .i_ar_ready        (i_ar_ready),
      .o_ar_addr         (o_ar_addr),
      .i_r_valid         (i_r_valid),
      .o_r_ready         (o_r_ready),
      .i_r_data          (i_r_data),
      .i_r_last          (i_r_last)
   );

   icache_arrays u_arrays
   (
      .clk   (clk),
      .arr   (arr_if),
      .i_tag (s2_paddr[ADDR_W-1 -: TAG_W])
   );

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else if (!o_stall)
      begin
         s1_valid <= 1'b1;
         s2_valid <= s1_valid & ~i_kill;   // Killed fetch never reports
      end
   end

   always_ff @(posedge clk)
   begin
      if (!o_stall)
      begin
         s1_vpo      <= i_vpo;
         s1_set      <= arr_if.set_addr;   // Address actually read, for the reload
         s1_pay_addr <= arr_if.pay_addr;
         o_ins       <= arr_if.hit_word;
      end
      else if (refill_beat & refill_hit_word)
         o_ins <= i_r_data;                // Critical word straight from the bus
      if (!o_stall & i_inv_we)
         inv_paddr_q <= i_inv_paddr;
   end

   assign o_valid = s2_valid & ~o_stall;

endmodule

//--- source/icache_ctrl.sv
`timescale 1ns/1ps
/*
   Refill is one BEATS-word burst from the line base; the requested word is flagged as it passes.
   An invalidate meeting a miss is served first, then the refill. Both end with a one-cycle reload.
*/
module icache_ctrl
(
   input  logic                          clk,
   input  logic                          i_reset,
   cache_array_if.ctrl                   arr,
   input  logic [icache_pkg::PAGE_W-1:0] i_vpo,
   input  logic                          i_s1_valid,
   input  logic [icache_pkg::SET_W-1:0]  i_s1_set,
   input  logic [icache_pkg::PAY_AW-1:0] i_s1_pay_addr,
   input  logic [icache_pkg::ADDR_W-1:0] i_s2_paddr,
   input  logic                          i_kill,
   input  logic                          i_inv_we,
   input  logic [icache_pkg::ADDR_W-1:0] i_inv_paddr,
   output logic                          o_stall,
   output logic                          o_refill_hit_word,
   output logic                          o_refill_beat,
   output logic                          o_ar_valid,
   input  logic                          i_ar_ready,
   output logic [icache_pkg::ADDR_W-1:0] o_ar_addr,
   input  logic                          i_r_valid,
   output logic                          o_r_ready,
   input  icache_pkg::insn_t             i_r_data,
   input  logic                          i_r_last
);
   import icache_pkg::*;

   state_t                   state;
   state_t                   state_nxt;
   logic [SET_W-1:0]         boot_cnt;
   logic [$clog2(BEATS)-1:0] beat_cnt;   // Word of the line being written
   logic [WAY_W-1:0]         rr_cnt;
   logic [WAY_W-1:0]         victim_way;
   logic [ADDR_W-1:0]        miss_paddr;
   logic                     miss;
   logic                     miss_pend;  // Miss seen together with an invalidate
   logic                     r_hs;

   assign miss = i_s1_valid & ~arr.hit & ~i_kill;
   assign r_hs = i_r_valid & o_r_ready;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_BOOT:
            if (boot_cnt == '1)
               state_nxt = ST_IDLE;
         ST_IDLE:
            if (i_inv_we)
               state_nxt = ST_INVALIDATE;
            else if (miss)
               state_nxt = ST_REPLACE;
         ST_REPLACE:
            state_nxt = ST_REFILL;
         ST_REFILL:
            if (r_hs & i_r_last)
               state_nxt = ST_RELOAD;
         ST_INVALIDATE:
            state_nxt = miss_pend ? ST_REPLACE : ST_RELOAD;
         ST_RELOAD:
            state_nxt = ST_IDLE;
         default:
            state_nxt = ST_BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         state      <= ST_BOOT;
         boot_cnt   <= '0;
         beat_cnt   <= '0;
         rr_cnt     <= '0;
         miss_pend  <= 1'b0;
         o_ar_valid <= 1'b0;
      end
      else
      begin
         state  <= state_nxt;
         rr_cnt <= rr_cnt + 1'b1;           // Free-running victim pointer
         if (state == ST_BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         if (r_hs)
            beat_cnt <= beat_cnt + 1'b1;    // Wraps back to 0 on the last beat
         if (state == ST_IDLE)
            miss_pend <= i_inv_we & miss;
         if (state == ST_REPLACE)
            o_ar_valid <= 1'b1;
         else if (i_ar_ready)
            o_ar_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!o_stall)
         miss_paddr <= i_s2_paddr;          // Frozen for the whole refill
      if (state == ST_REPLACE)
      begin
         victim_way <= rr_cnt;
         o_ar_addr  <= {miss_paddr[ADDR_W-1:LINE_W], {LINE_W{1'b0}}};
      end
   end

   // Array addresses per state
   always_comb
   begin
      arr.set_addr = i_vpo[LINE_W +: SET_W];
      arr.pay_addr = i_vpo[WORD_BYTES_W +: PAY_AW];
      case (state)
         ST_BOOT:
            arr.set_addr = boot_cnt;
         ST_INVALIDATE:
            arr.set_addr = i_inv_paddr[LINE_W +: SET_W];
         ST_REPLACE:
            arr.set_addr = miss_paddr[LINE_W +: SET_W];
         ST_REFILL:
            arr.pay_addr = {miss_paddr[LINE_W +: SET_W], beat_cnt};
         ST_RELOAD:
         begin
            // Stage-1 read was stale after the array writes
            arr.set_addr = i_s1_set;
            arr.pay_addr = i_s1_pay_addr;
         end
         default: ;
      endcase
   end

   assign arr.rd_en     = ~o_stall | (state == ST_RELOAD);
   assign arr.tag_wdata = (state == ST_REPLACE)
                          ? tag_entry_t'{tag: miss_paddr[ADDR_W-1 -: TAG_W], valid: 1'b1}
                          : '0;
   assign arr.pay_wdata = i_r_data;

   for (genvar w = 0; w < NUM_WAYS; w++)
   begin : g_we
      assign arr.tag_we[w] = (state == ST_BOOT) | (state == ST_INVALIDATE)
                             | ((state == ST_REPLACE) & (rr_cnt == WAY_W'(w)));
      assign arr.pay_we[w] = r_hs & (victim_way == WAY_W'(w));
   end

   assign o_stall           = (state != ST_IDLE);
   assign o_r_ready         = (state == ST_REFILL);
   assign o_refill_beat     = r_hs;
   assign o_refill_hit_word = (beat_cnt == miss_paddr[WORD_BYTES_W +: $clog2(BEATS)]);

endmodule

//--- source/icache_arrays.sv
`timescale 1ns/1ps
/*
   One tag RAM and one payload RAM per way, sharing the addresses.
   If more than one way matched, the lowest way would win.
*/
module icache_arrays
(
   input  logic                         clk,
   cache_array_if.arrays                arr,
   input  logic [icache_pkg::TAG_W-1:0] i_tag
);
   import icache_pkg::*;

   tag_entry_t          tag_q  [NUM_WAYS];
   insn_t               word_q [NUM_WAYS];
   logic [NUM_WAYS-1:0] hit_vec;

   for (genvar w = 0; w < NUM_WAYS; w++)
   begin : g_way
      sync_ram
      #(
         .entry_t (tag_entry_t),
         .DEPTH_W (SET_W)
      )
      u_tag_ram
      (
         .clk     (clk),
         .i_addr  (arr.set_addr),
         .i_rd_en (arr.rd_en),
         .i_we    (arr.tag_we[w]),
         .i_wdata (arr.tag_wdata),
         .o_rdata (tag_q[w])
      );

      sync_ram
      #(
         .entry_t (insn_t),
         .DEPTH_W (PAY_AW)
      )
      u_pay_ram
      (
         .clk     (clk),
         .i_addr  (arr.pay_addr),
         .i_rd_en (arr.rd_en),
         .i_we    (arr.pay_we[w]),
         .i_wdata (arr.pay_wdata),
         .o_rdata (word_q[w])
      );

      // Valid entry with a matching physical tag
      assign hit_vec[w] = tag_q[w].valid & (tag_q[w].tag == i_tag);
   end

   assign arr.hit = |hit_vec;

   // Priority select of the matching way
   always_comb
   begin
      arr.hit_word = word_q[0];
      for (int w = NUM_WAYS - 1; w >= 0; w--)
      begin
         if (hit_vec[w])
            arr.hit_word = word_q[w];
      end
   end

endmodule

//--- source/sync_ram.sv
`timescale 1ns/1ps
/*
   Single port, registered read. A read at a written address returns the old entry.
   Output holds its value while i_rd_en is low.
*/
module sync_ram
#(
   parameter type entry_t = logic [31:0],
   parameter int  DEPTH_W = 2
)
(
   input  logic               clk,
   input  logic [DEPTH_W-1:0] i_addr,
   input  logic               i_rd_en,
   input  logic               i_we,
   input  entry_t             i_wdata,
   output entry_t             o_rdata
);

   entry_t mem [0:(1<<DEPTH_W)-1];

   always_ff @(posedge clk)
   begin
      if (i_we)
         mem[i_addr] <= i_wdata;
      if (i_rd_en)
         o_rdata <= mem[i_addr];   // Held between reads
   end

endmodule

//--- source/cache_array_if.sv
`timescale 1ns/1ps
/*
   Writes land on the edge where the enable is high.
   Read data is valid the cycle after an enabled read edge.
*/
interface cache_array_if;
   import icache_pkg::*;

   logic [SET_W-1:0]    set_addr;   // Tag RAM index
   logic [PAY_AW-1:0]   pay_addr;   // {set, word in line}
   logic                rd_en;
   logic [NUM_WAYS-1:0] tag_we;
   tag_entry_t          tag_wdata;
   logic [NUM_WAYS-1:0] pay_we;
   insn_t               pay_wdata;

   // Compare result for the stage-2 tag
   logic                hit;
   insn_t               hit_word;

   modport ctrl (
      output set_addr, pay_addr, rd_en, tag_we, tag_wdata, pay_we, pay_wdata,
      input  hit, hit_word
   );

   modport arrays (
      input  set_addr, pay_addr, rd_en, tag_we, tag_wdata, pay_we, pay_wdata,
      output hit, hit_word
   );

endinterface

//--- source/icache_pkg.sv
/*
   Cache geometry is fixed: 16-bit addresses, 16-byte lines, 4 sets, 2 ways.
   Bus data width equals the 32-bit instruction width.
*/
package icache_pkg;

   localparam int ADDR_W       = 16;                    // Physical address
   localparam int PAGE_W       = 12;                    // Page offset
   localparam int LINE_W       = 4;                     // Byte offset in a line
   localparam int SET_W        = 2;
   localparam int WAY_W        = 1;
   localparam int NUM_WAYS     = 2;
   localparam int WORD_BYTES_W = 2;                     // Byte offset in a fetch word
   localparam int TAG_W        = ADDR_W - SET_W - LINE_W;
   localparam int PAY_AW       = SET_W + LINE_W - WORD_BYTES_W;
   localparam int BEATS        = 4;                     // Words per refill burst

   typedef logic [31:0] insn_t;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic             valid;
   } tag_entry_t;

   typedef enum logic [2:0] {
      ST_BOOT,
      ST_IDLE,
      ST_REPLACE,
      ST_REFILL,
      ST_INVALIDATE,
      ST_RELOAD
   } state_t;

endpackage
